// ==== verilog/ans_macros.svh ====
/*
 * widths shared by the noise shaped pwm design
 *   fraction and integer level widths
 *   sample fifo depth
 *   pwm frame length in clock cycles
 */
`ifndef ANS_MACROS_SVH
`define ANS_MACROS_SVH

// fractional part of the target, one accumulator per stage
`define ANS_FRAC_BITS 24

// integer part of the target and pwm level
`define ANS_INT_BITS 8

// entries between shaper and pwm
`define ANS_FIFO_DEPTH 4

// one cycle per level step
`define ANS_FRAME_LEN (1 << `ANS_INT_BITS)

`endif

// ==== verilog/ans_pkg.sv ====
/*
 * types shared by the rtl and the testbench
 *   target, fraction, level and frame count words
 *   signed carry correction
 *   handshake fsm states
 */
`default_nettype none
`include "ans_macros.svh"

package ans_pkg;

  // integer part sits above the fraction
  typedef logic [`ANS_INT_BITS+`ANS_FRAC_BITS-1:0] target_t;

  // accumulator and residue word
  typedef logic [`ANS_FRAC_BITS-1:0] frac_t;

  typedef logic [`ANS_INT_BITS-1:0] level_t;

  // sum of differentiated carries, -7 .. +8
  typedef logic signed [4:0] corr_t;

  typedef logic [`ANS_INT_BITS-1:0] frame_cnt_t;

  // four phase req/ack sequencing
  typedef enum logic [1:0] {IDLE, REQ, WAIT_DROP} hs_state_t;

endpackage

`default_nettype wire

// ==== verilog/mash_stage.sv ====
/*
 * first order accumulator of the mash cascade
 *   overflow of the add is the stage carry
 *   updated sum feeds the next stage
 */
`timescale 1ns/1ps
`default_nettype none
`include "ans_macros.svh"

module mash_stage import ans_pkg::*; (
  input  logic  clk,
  input  logic  reset_i,
  input  logic  step_i,
  input  frac_t in_i,
  output logic  carry_o,
  output frac_t residue_o
);

  frac_t acc;
  // one extra bit holds the overflow
  logic [`ANS_FRAC_BITS:0] sum;

  assign sum       = {1'b0, acc} + {1'b0, in_i};
  assign carry_o   = sum[`ANS_FRAC_BITS];
  // next stage adds the new value within the same step
  assign residue_o = sum[`ANS_FRAC_BITS-1:0];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      acc <= '0;
    end else if (step_i) begin
      acc <= residue_o;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/noise_shaper.sv ====
/*
 * fourth order mash 1-1-1-1 noise shaper
 *   four accumulator stages on the target fraction
 *   registered carry differentiators and alignment delays
 *   correction sum with saturation to the level range
 *   four phase req/ack source, one cascade step per transfer
 */
`timescale 1ns/1ps
`default_nettype none
`include "ans_macros.svh"

module noise_shaper import ans_pkg::*; (
  input  logic    clk,
  input  logic    reset_i,
  input  target_t target_i,
  output logic    req_o,
  input  logic    ack_i,
  output level_t  level_o
);

  localparam int NSTAGE = 4;
  // every contribution passes three step registers
  localparam int NDLY   = NSTAGE - 1;
  localparam int SUM_W  = `ANS_INT_BITS + 2;

  hs_state_t               state;
  logic                    step;
  target_t                 target_q;
  frac_t                   stage_in [NSTAGE];
  logic [NSTAGE-1:0]       carry;
  corr_t                   tap [NSTAGE][NDLY];
  corr_t                   pipe [NSTAGE][NDLY];
  corr_t                   prev [NSTAGE*(NSTAGE-1)/2];
  level_t                  int_dly [NDLY];
  corr_t                   corr;
  logic signed [SUM_W-1:0] lvl_sum;
  level_t                  lvl_sat;

  // slot of the held input for difference j of stage k
  function automatic int prev_idx(int k, int j);
    return k * (k - 1) / 2 + j;
  endfunction

  // cascade advances only while idle
  assign step        = (state == IDLE);
  assign stage_in[0] = target_q[`ANS_FRAC_BITS-1:0];

  for (genvar k = 0; k < NSTAGE; k++) begin : g_stage
    if (k < NSTAGE - 1) begin : g_mid
      mash_stage u_stage (
        .clk       (clk),
        .reset_i   (reset_i),
        .step_i    (step),
        .in_i      (stage_in[k]),
        .carry_o   (carry[k]),
        .residue_o (stage_in[k+1])
      );
    end else begin : g_last
      // last residue has no consumer
      mash_stage u_stage (
        .clk       (clk),
        .reset_i   (reset_i),
        .step_i    (step),
        .in_i      (stage_in[k]),
        .carry_o   (carry[k]),
        .residue_o ()
      );
    end
  end

  // input of each pipe register
  always_comb begin
    for (int k = 0; k < NSTAGE; k++) begin
      tap[k][0] = corr_t'(carry[k]);
      for (int j = 1; j < NDLY; j++) begin
        tap[k][j] = pipe[k][j-1];
      end
    end
  end

  // stage k takes k differences first, plain delays after
  always_ff @(posedge clk) begin
    if (reset_i) begin
      pipe    <= '{default: '0};
      prev    <= '{default: '0};
      int_dly <= '{default: '0};
    end else if (step) begin
      for (int k = 0; k < NSTAGE; k++) begin
        for (int j = 0; j < NDLY; j++) begin
          if (j < k) begin
            pipe[k][j]           <= tap[k][j] - prev[prev_idx(k, j)];
            prev[prev_idx(k, j)] <= tap[k][j];
          end else begin
            pipe[k][j] <= tap[k][j];
          end
        end
      end
      // integer part follows the same three steps
      int_dly[0] <= target_q[`ANS_INT_BITS+`ANS_FRAC_BITS-1:`ANS_FRAC_BITS];
      for (int j = 1; j < NDLY; j++) begin
        int_dly[j] <= int_dly[j-1];
      end
    end
  end

  always_comb begin
    corr = '0;
    for (int k = 0; k < NSTAGE; k++) begin
      corr = corr + pipe[k][NDLY-1];
    end
    lvl_sum = $signed({2'b00, int_dly[NDLY-1]}) + SUM_W'(corr);
    // top bit is the sign, next one flags above 255
    if (lvl_sum[SUM_W-1]) begin
      lvl_sat = '0;
    end else if (lvl_sum[SUM_W-2]) begin
      lvl_sat = '1;
    end else begin
      lvl_sat = lvl_sum[`ANS_INT_BITS-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state    <= IDLE;
      req_o    <= 1'b0;
      target_q <= '0;
      level_o  <= '0;
    end else begin
      case (state)
        IDLE: begin
          // step cycle, level taken from the settled pipe
          target_q <= target_i;
          level_o  <= lvl_sat;
          state    <= REQ;
        end
        REQ: begin
          // level is stable one cycle before req rises
          if (!req_o) begin
            req_o <= 1'b1;
          end else if (ack_i) begin
            req_o <= 1'b0;
            state <= WAIT_DROP;
          end
        end
        WAIT_DROP: begin
          if (!ack_i) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/sample_fifo.sv ====
/*
 * small level fifo between shaper and pwm
 *   circular buffer with read and write pointers and a count
 *   four phase req/ack sink on the write side
 *   four phase req/ack source on the read side
 */
`timescale 1ns/1ps
`default_nettype none
`include "ans_macros.svh"

module sample_fifo import ans_pkg::*; (
  input  logic   clk,
  input  logic   reset_i,
  input  logic   wr_req_i,
  output logic   wr_ack_o,
  input  level_t wr_level_i,
  input  logic   rd_req_i,
  output logic   rd_ack_o,
  output level_t rd_level_o
);

  localparam int               PTR_W    = $clog2(`ANS_FIFO_DEPTH);
  localparam logic [PTR_W:0]   FULL_CNT = (PTR_W + 1)'(`ANS_FIFO_DEPTH);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`ANS_FIFO_DEPTH - 1);

  level_t           mem [`ANS_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             wr_take;
  logic             rd_give;
  logic             push;
  logic             pop;

  // ack rises only with room or data
  assign wr_take = wr_req_i && !wr_ack_o && (count != FULL_CNT);
  assign rd_give = rd_req_i && !rd_ack_o && (count != '0);
  // pointers and count move when ack drops
  assign push    = wr_ack_o && !wr_req_i;
  assign pop     = rd_ack_o && !rd_req_i;

  // storage written as the write ack rises
  always_ff @(posedge clk) begin
    if (wr_take) begin
      mem[wr_ptr] <= wr_level_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ack_o   <= 1'b0;
      rd_ack_o   <= 1'b0;
      rd_level_o <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
    end else begin
      // write side
      if (wr_take) begin
        wr_ack_o <= 1'b1;
      end else if (push) begin
        wr_ack_o <= 1'b0;
        wr_ptr   <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      // read side, head held on the output with the ack
      if (rd_give) begin
        rd_level_o <= mem[rd_ptr];
        rd_ack_o   <= 1'b1;
      end else if (pop) begin
        rd_ack_o <= 1'b0;
        rd_ptr   <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pwm_generator.sv ====
/*
 * pwm output stage
 *   frame counter and frame marker
 *   level prefetch over a four phase req/ack sink
 *   registered comparator, level held on fifo underflow
 */
`timescale 1ns/1ps
`default_nettype none
`include "ans_macros.svh"

module pwm_generator import ans_pkg::*; (
  input  logic   clk,
  input  logic   reset_i,
  output logic   req_o,
  input  logic   ack_i,
  input  level_t level_i,
  output logic   pwm_o,
  output logic   frame_o
);

  localparam frame_cnt_t LAST_CNT = frame_cnt_t'(`ANS_FRAME_LEN - 1);

  hs_state_t  state;
  frame_cnt_t cnt;
  frame_cnt_t cnt_nxt;
  level_t     prefetch;
  logic       got;
  level_t     active;
  level_t     active_nxt;
  logic       capture;
  logic       frame_end;

  assign frame_o   = (cnt == '0);
  assign frame_end = (cnt == LAST_CNT);
  assign capture   = (state == REQ) && ack_i;
  assign cnt_nxt   = frame_end ? '0 : cnt + 1'b1;

  // new level at frame start, old one kept if nothing arrived
  always_comb begin
    active_nxt = active;
    if (frame_end) begin
      if (capture) begin
        active_nxt = level_i;
      end else if (got) begin
        active_nxt = prefetch;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      prefetch <= level_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state  <= IDLE;
      req_o  <= 1'b0;
      got    <= 1'b0;
      cnt    <= '0;
      active <= '0;
      pwm_o  <= 1'b0;
    end else begin
      cnt    <= cnt_nxt;
      active <= active_nxt;
      // high for the first active cycles of the frame
      pwm_o  <= (cnt_nxt < active_nxt);
      case (state)
        IDLE: begin
          // fetch for the next frame right after this one starts
          if (frame_o) begin
            req_o <= 1'b1;
            state <= REQ;
          end
        end
        REQ: begin
          if (capture) begin
            req_o <= 1'b0;
            got   <= 1'b1;
            state <= WAIT_DROP;
          end
        end
        WAIT_DROP: begin
          if (!ack_i) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
      // boundary uses up the prefetched level
      if (frame_end) begin
        got <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ans_pwm_top.sv ====
/*
 * top level of the noise shaped pwm
 *   shaper, level fifo and pwm stage on one clock
 */
`timescale 1ns/1ps
`default_nettype none

module ans_pwm_top import ans_pkg::*; (
  input  logic    clk,
  input  logic    reset_i,
  input  target_t target_i,
  output logic    pwm_o,
  output logic    frame_o
);

  // shaper to fifo
  logic   prod_req;
  logic   prod_ack;
  level_t prod_level;
  // fifo to pwm
  logic   cons_req;
  logic   cons_ack;
  level_t cons_level;

  noise_shaper u_shaper (
    .clk      (clk),
    .reset_i  (reset_i),
    .target_i (target_i),
    .req_o    (prod_req),
    .ack_i    (prod_ack),
    .level_o  (prod_level)
  );

  sample_fifo u_fifo (
    .clk        (clk),
    .reset_i    (reset_i),
    .wr_req_i   (prod_req),
    .wr_ack_o   (prod_ack),
    .wr_level_i (prod_level),
    .rd_req_i   (cons_req),
    .rd_ack_o   (cons_ack),
    .rd_level_o (cons_level)
  );

  pwm_generator u_pwm (
    .clk     (clk),
    .reset_i (reset_i),
    .req_o   (cons_req),
    .ack_i   (cons_ack),
    .level_i (cons_level),
    .pwm_o   (pwm_o),
    .frame_o (frame_o)
  );

endmodule

`default_nettype wire

// ==== bench/ans_pwm_properties.sv ====
/*
 * concurrent checks on the noise shaped pwm top
 *   frame marker width and 256 cycle period
 *   pwm high only in a prefix of the frame
 *   quiet handshake lines after reset
 *   four phase rules on the shaper and pwm links
 */
`timescale 1ns/1ps
`default_nettype none
`include "ans_macros.svh"

module ans_pwm_properties import ans_pkg::*; (
  input logic   clk,
  input logic   reset_i,
  input logic   pwm_o,
  input logic   frame_o,
  input logic   prod_req,
  input logic   prod_ack,
  input level_t prod_level,
  input logic   cons_req,
  input logic   cons_ack,
  input level_t cons_level
);

  // cycles since the last frame marker
  int gap;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      // marker due in the first cycle after reset
      gap <= `ANS_FRAME_LEN;
    end else if (frame_o) begin
      gap <= 1;
    end else begin
      gap <= gap + 1;
    end
  end

  // one cycle wide and exactly on the frame grid
  a_frame_period: assert property (@(posedge clk) disable iff (reset_i)
    frame_o == (gap == `ANS_FRAME_LEN))
    else $error("frame marker off the frame grid, gap %0d", gap);

  // once low inside a frame pwm stays low
  a_pwm_prefix: assert property (@(posedge clk) disable iff (reset_i)
    (pwm_o && !frame_o) |-> $past(pwm_o))
    else $error("pwm high after a low cycle within the frame");

  a_reset_quiet: assert property (@(posedge clk)
    reset_i |=> !(prod_req || prod_ack || cons_req || cons_ack || pwm_o))
    else $error("handshake or pwm line high right after reset");

  // shaper to fifo link
  a_prod_rise: assert property (@(posedge clk) disable iff (reset_i)
    $rose(prod_req) |-> !prod_ack)
    else $error("producer req raised while ack still high");

  a_prod_fall: assert property (@(posedge clk) disable iff (reset_i)
    prod_ack |=> !prod_req)
    else $error("producer req still high after ack");

  a_prod_hold: assert property (@(posedge clk) disable iff (reset_i)
    (prod_req && !prod_ack && $past(prod_req && !prod_ack)) |-> $stable(prod_level))
    else $error("producer level changed while waiting for ack");

  // fifo to pwm link
  a_cons_rise: assert property (@(posedge clk) disable iff (reset_i)
    $rose(cons_req) |-> !cons_ack)
    else $error("consumer req raised while ack still high");

  a_cons_fall: assert property (@(posedge clk) disable iff (reset_i)
    cons_ack |=> !cons_req)
    else $error("consumer req still high after ack");

  a_cons_hold: assert property (@(posedge clk) disable iff (reset_i)
    (cons_req && !cons_ack && $past(cons_req && !cons_ack)) |-> $stable(cons_level))
    else $error("fifo level changed while consumer waits for ack");

endmodule

bind ans_pwm_top ans_pwm_properties u_props (
  .clk        (clk),
  .reset_i    (reset_i),
  .pwm_o      (pwm_o),
  .frame_o    (frame_o),
  .prod_req   (prod_req),
  .prod_ack   (prod_ack),
  .prod_level (prod_level),
  .cons_req   (cons_req),
  .cons_ack   (cons_ack),
  .cons_level (cons_level)
);

`default_nettype wire

// ==== bench/ans_pwm_tb.sv ====
/*
 * testbench for the noise shaped pwm top
 *   clock, reset and lfsr driven targets
 *   frame levels measured from pwm high time
 *   level range and long run mean checks
 *   cycle limit on the whole run
 */
`timescale 1ns/1ps
`default_nettype none
`include "ans_macros.svh"

module ans_pwm_tb import ans_pkg::*; ();

  localparam int          CLK_HALF      = 20;
  localparam int          DRIVE_DELAY   = 2;
  localparam int          RESET_CYCLES  = 5;
  localparam int          FRAMES        = 40;
  localparam int          NUM_TESTS     = 5;
  // pipeline transient, later frames carry the target
  localparam int          SETTLE_FRAMES = 6;
  // six spare frames per test
  localparam int          MAX_CYCLES    =
    NUM_TESTS * (RESET_CYCLES + (FRAMES + 6) * `ANS_FRAME_LEN);
  localparam int          TRACK_SLACK   = 16;
  localparam real         FRAC_SCALE    = 2.0 ** `ANS_FRAC_BITS;
  localparam logic [31:0] SEED          = 32'h48ad9997;
  localparam logic [31:0] LFSR_TAPS     = 32'hd0000001;

  logic        clk;
  logic        reset_i;
  target_t     target_i;
  logic        pwm_o;
  logic        frame_o;
  logic [31:0] lfsr;
  int          cycles;

  ans_pwm_top DUT (
    .clk      (clk),
    .reset_i  (reset_i),
    .target_i (target_i),
    .pwm_o    (pwm_o),
    .frame_o  (frame_o)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // run limit
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("TESTS FAILED");
    $fatal(1, "run did not finish within %0d cycles", MAX_CYCLES);
  end

  // galois shift right, taps applied when a one falls out
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check_level(input string name, input int frame, input int lo,
                             input int hi, input int act);
    assert (act >= lo && act <= hi) else begin
      if (lo == hi) begin
        $display("[ERROR] %s frame %0d: expected %0d, actual %0d", name, frame, lo, act);
      end else begin
        $display("[ERROR] %s frame %0d: expected %0d..%0d, actual %0d",
                 name, frame, lo, hi, act);
      end
      $display("TESTS FAILED");
      $fatal(1, "%s level check failed", name);
    end
  endtask

  // exact sum in fraction units, slack in whole levels
  task automatic verify_mean(input string name, input int frame, input longint exact,
                             input longint sum);
    longint slack;
    longint act;
    slack = longint'(TRACK_SLACK) << `ANS_FRAC_BITS;
    act   = sum << `ANS_FRAC_BITS;
    assert (act >= exact - slack && act <= exact + slack) else begin
      $display("[ERROR] %s frame %0d: expected level sum %0.3f +-%0d, actual %0d",
               name, frame, real'(exact) / FRAC_SCALE, TRACK_SLACK, sum);
      $display("TESTS FAILED");
      $fatal(1, "%s mean drifted from the target", name);
    end
  endtask

  task automatic start_test(input target_t tgt);
    @(posedge clk);
    #DRIVE_DELAY;
    reset_i  = 1'b1;
    target_i = tgt;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset_i = 1'b0;
    // first cycle after reset opens frame 0
    @(negedge clk);
    while (!frame_o) begin
      @(negedge clk);
    end
  endtask

  // starts on a marker cycle, ends on the next marker
  task automatic measure_frame(output int level);
    int high;
    high = 0;
    do begin
      if (pwm_o) begin
        high++;
      end
      @(negedge clk);
    end while (!frame_o);
    level = high;
  endtask

  task automatic run_test(input string name, input level_t int_part, input frac_t frac,
                          input bit track);
    target_t tgt;
    int      level;
    int      lo;
    int      hi;
    longint  sum;
    longint  exact;
    tgt = {int_part, frac};
    sum = 0;
    // whole target gives a flat level
    if (frac == '0) begin
      lo = int'(int_part);
      hi = int'(int_part);
    end else begin
      lo = (int'(int_part) < 7) ? 0 : int'(int_part) - 7;
      hi = (int'(int_part) > 247) ? 255 : int'(int_part) + 8;
    end
    start_test(tgt);
    for (int f = 0; f < FRAMES; f++) begin
      measure_frame(level);
      // a frame fully high would mean a level above 255
      check_level(name, f, 0, `ANS_FRAME_LEN - 1, level);
      if (f == 0) begin
        check_level(name, f, 0, 0, level);
      end else if (f >= SETTLE_FRAMES) begin
        check_level(name, f, lo, hi, level);
        if (track) begin
          sum   = sum + longint'(level);
          exact = longint'(f - SETTLE_FRAMES + 1) * longint'(tgt);
          verify_mean(name, f, exact, sum);
        end
      end
    end
  endtask

  initial begin
    logic [31:0] bits;
    level_t      int_part;
    frac_t       frac;
    reset_i  = 1'b1;
    target_i = '0;
    lfsr     = SEED;

    take_bits(8, bits);
    int_part = level_t'(16 + bits % 224);
    run_test("integer", int_part, '0, 1'b1);

    // two random targets inside the unsaturated range
    repeat (2) begin
      take_bits(8, bits);
      int_part = level_t'(16 + bits % 224);
      take_bits(24, bits);
      frac = bits[23:0] | 24'd1;
      run_test("fraction", int_part, frac, 1'b1);
    end

    take_bits(24, bits);
    frac = bits[23:0] | 24'd1;
    run_test("saturate high", 8'd255, frac, 1'b0);

    // under a sixteenth of a level
    take_bits(20, bits);
    frac = {4'h0, bits[19:0]} | 24'd1;
    run_test("saturate low", 8'd0, frac, 1'b0);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verilog
verilog/ans_pkg.sv
verilog/mash_stage.sv
verilog/noise_shaper.sv
verilog/sample_fifo.sv
verilog/pwm_generator.sv
verilog/ans_pwm_top.sv
bench/ans_pwm_properties.sv
bench/ans_pwm_tb.sv

// ==== Makefile ====
# Verilator build and run of the noise shaped pwm testbench

VERILATOR ?= verilator
TOP       ?= ans_pwm_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
EXTRA     ?=

VFLAGS = --timing --assert -f $(FILELIST) --top-module $(TOP) $(EXTRA)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

# the simulation exit status carries pass or fail
sim:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
